// File: hw/id_pkg.sv
`default_nettype none

package id_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // ALU operations handed to execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_LUI
    } alu_op_e;

    // Branch kinds resolved in decode
    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_B,
        BR_BL,
        BR_JIRL
    } br_kind_e;

    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
    } fetch_bus_t;

    typedef struct packed {
        alu_op_e           alu_op;
        br_kind_e          br_kind;
        logic              src1_is_pc;
        logic              src2_is_imm;
        logic              res_from_mem;
        logic              gr_we;
        logic              mem_we;
        logic              ine;
        logic [REG_AW-1:0] dest;
        logic [REG_AW-1:0] raddr1;
        logic [REG_AW-1:0] raddr2;
        logic              use1;
        logic              use2;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   br_offs;
    } decode_t;

    // Result record from a later stage, used for bypass
    typedef struct packed {
        logic              valid;
        logic              gr_we;
        logic              is_load;
        logic [REG_AW-1:0] dest;
        logic [XLEN-1:0]   result;
    } fwd_t;

    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] addr;
        logic [XLEN-1:0]   data;
    } wb_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } br_bus_t;

    typedef struct packed {
        alu_op_e           alu_op;
        logic              src1_is_pc;
        logic              src2_is_imm;
        logic              res_from_mem;
        logic              gr_we;
        logic              mem_we;
        logic              ine;
        logic [REG_AW-1:0] dest;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   rj_value;
        logic [XLEN-1:0]   rkd_value;
        logic [XLEN-1:0]   pc;
    } exec_bus_t;

endpackage

`default_nettype wire

// File: hw/inst_decoder.sv
`default_nettype none

module inst_decoder (
    input  logic [id_pkg::XLEN-1:0] inst,
    output id_pkg::decode_t         dec
);
    import id_pkg::*;

    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rj;
    logic [REG_AW-1:0] rk;
    logic [XLEN-1:0]   si12;
    logic [XLEN-1:0]   si20;
    logic [XLEN-1:0]   offs16;
    logic [XLEN-1:0]   offs26;
    logic              rr_hit;
    alu_op_e           rr_op;

    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    // Immediates, branch offsets are word aligned
    assign si12   = {{20{inst[21]}}, inst[21:10]};
    assign si20   = {inst[24:5], 12'b0};
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b0};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};

    // Three-register ALU group, opcode 0x001 in bits 31:20
    always_comb begin
        rr_hit = (inst[31:20] == 12'h001);
        rr_op  = ALU_ADD;
        case (inst[19:15])
            5'h00:   rr_op = ALU_ADD;
            5'h02:   rr_op = ALU_SUB;
            5'h04:   rr_op = ALU_SLT;
            5'h05:   rr_op = ALU_SLTU;
            5'h08:   rr_op = ALU_NOR;
            5'h09:   rr_op = ALU_AND;
            5'h0a:   rr_op = ALU_OR;
            5'h0b:   rr_op = ALU_XOR;
            default: rr_hit = 1'b0;
        endcase
    end

    always_comb begin
        dec         = '0;
        dec.alu_op  = ALU_ADD;
        dec.br_kind = BR_NONE;
        dec.dest    = rd;
        dec.raddr1  = rj;
        dec.raddr2  = rk;
        dec.br_offs = offs16;
        if (rr_hit) begin
            dec.alu_op = rr_op;
            dec.gr_we  = 1'b1;
            dec.use1   = 1'b1;
            dec.use2   = 1'b1;
        end else begin
            casez (inst[31:22])
                10'b0000001010: begin
                    // addi.w
                    dec.src2_is_imm = 1'b1;
                    dec.imm         = si12;
                    dec.gr_we       = 1'b1;
                    dec.use1        = 1'b1;
                end
                10'b0001010???: begin
                    // lu12i.w
                    dec.alu_op      = ALU_LUI;
                    dec.src2_is_imm = 1'b1;
                    dec.imm         = si20;
                    dec.gr_we       = 1'b1;
                end
                10'b0010100010: begin
                    // ld.w
                    dec.res_from_mem = 1'b1;
                    dec.src2_is_imm  = 1'b1;
                    dec.imm          = si12;
                    dec.gr_we        = 1'b1;
                    dec.use1         = 1'b1;
                end
                10'b0010100110: begin
                    // st.w stores rd
                    dec.mem_we      = 1'b1;
                    dec.src2_is_imm = 1'b1;
                    dec.imm         = si12;
                    dec.raddr2      = rd;
                    dec.use1        = 1'b1;
                    dec.use2        = 1'b1;
                end
                10'b010011????: begin
                    // jirl links pc + 4 into rd
                    dec.br_kind     = BR_JIRL;
                    dec.src1_is_pc  = 1'b1;
                    dec.src2_is_imm = 1'b1;
                    dec.imm         = 32'd4;
                    dec.gr_we       = 1'b1;
                    dec.use1        = 1'b1;
                end
                10'b010100????: begin
                    dec.br_kind = BR_B;
                    dec.br_offs = offs26;
                end
                10'b010101????: begin
                    // bl always links into r1
                    dec.br_kind     = BR_BL;
                    dec.br_offs     = offs26;
                    dec.src1_is_pc  = 1'b1;
                    dec.src2_is_imm = 1'b1;
                    dec.imm         = 32'd4;
                    dec.gr_we       = 1'b1;
                    dec.dest        = 5'd1;
                end
                10'b010110????,
                10'b010111????,
                10'b011000????,
                10'b011001????: begin
                    // Conditional branches compare rj with rd
                    case (inst[27:26])
                        2'b10:   dec.br_kind = BR_BEQ;
                        2'b11:   dec.br_kind = BR_BNE;
                        2'b00:   dec.br_kind = BR_BLT;
                        default: dec.br_kind = BR_BGE;
                    endcase
                    dec.raddr2 = rd;
                    dec.use1   = 1'b1;
                    dec.use2   = 1'b1;
                end
                default: begin
                    dec.ine = 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/regfile.sv
`default_nettype none

module regfile (
    input  logic                      clk,
    input  logic [id_pkg::REG_AW-1:0] raddr1,
    input  logic [id_pkg::REG_AW-1:0] raddr2,
    input  id_pkg::wb_t               wb,
    output logic [id_pkg::XLEN-1:0]   rdata1,
    output logic [id_pkg::XLEN-1:0]   rdata2
);
    import id_pkg::*;

    logic [XLEN-1:0] regs [2**REG_AW];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (wb.we && (wb.addr != '0)) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // Asynchronous reads, r0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: hw/operand_forward.sv
`default_nettype none

module operand_forward (
    input  id_pkg::decode_t         dec,
    input  logic [id_pkg::XLEN-1:0] rdata1,
    input  logic [id_pkg::XLEN-1:0] rdata2,
    input  id_pkg::fwd_t            es_fwd,
    input  id_pkg::fwd_t            ms_fwd,
    input  id_pkg::fwd_t            ws_fwd,
    output logic [id_pkg::XLEN-1:0] rj_value,
    output logic [id_pkg::XLEN-1:0] rkd_value,
    output logic                    load_block
);
    import id_pkg::*;

    logic es_hit1;
    logic ms_hit1;
    logic ws_hit1;
    logic es_hit2;
    logic ms_hit2;
    logic ws_hit2;

    // A record matches a source that is actually read, never r0
    function automatic logic fwd_hit(input fwd_t f, input logic [REG_AW-1:0] src,
                                     input logic used);
        return used && f.valid && f.gr_we && (f.dest != '0) && (f.dest == src);
    endfunction

    // Youngest producer wins
    function automatic logic [XLEN-1:0] pick(input logic es_hit, input logic ms_hit,
                                             input logic ws_hit,
                                             input logic [XLEN-1:0] rf_value);
        if (es_hit) begin
            return es_fwd.result;
        end else if (ms_hit) begin
            return ms_fwd.result;
        end else if (ws_hit) begin
            return ws_fwd.result;
        end
        return rf_value;
    endfunction

    assign es_hit1 = fwd_hit(es_fwd, dec.raddr1, dec.use1);
    assign ms_hit1 = fwd_hit(ms_fwd, dec.raddr1, dec.use1);
    assign ws_hit1 = fwd_hit(ws_fwd, dec.raddr1, dec.use1);
    assign es_hit2 = fwd_hit(es_fwd, dec.raddr2, dec.use2);
    assign ms_hit2 = fwd_hit(ms_fwd, dec.raddr2, dec.use2);
    assign ws_hit2 = fwd_hit(ws_fwd, dec.raddr2, dec.use2);

    assign rj_value  = pick(es_hit1, ms_hit1, ws_hit1, rdata1);
    assign rkd_value = pick(es_hit2, ms_hit2, ws_hit2, rdata2);

    // Load data only exists once the load leaves memory
    assign load_block = es_fwd.is_load & (es_hit1 | es_hit2);

endmodule

`default_nettype wire

// File: hw/branch_unit.sv
`default_nettype none

module branch_unit (
    input  id_pkg::decode_t         dec,
    input  logic [id_pkg::XLEN-1:0] pc,
    input  logic [id_pkg::XLEN-1:0] rj_value,
    input  logic [id_pkg::XLEN-1:0] rkd_value,
    output logic                    cond_taken,
    output logic [id_pkg::XLEN-1:0] target
);
    import id_pkg::*;

    logic [XLEN:0] diff;
    logic          eq;
    logic          ltu;
    logic          lt;

    // One subtraction, the borrow gives unsigned less-than
    assign diff = {1'b0, rj_value} - {1'b0, rkd_value};
    assign eq   = (diff[XLEN-1:0] == '0);
    assign ltu  = diff[XLEN];
    // Differing signs decide signed order directly
    assign lt   = (rj_value[XLEN-1] ^ rkd_value[XLEN-1]) ? rj_value[XLEN-1] : ltu;

    always_comb begin
        case (dec.br_kind)
            BR_BEQ:                cond_taken = eq;
            BR_BNE:                cond_taken = ~eq;
            BR_BLT:                cond_taken = lt;
            BR_BGE:                cond_taken = ~lt;
            BR_B, BR_BL, BR_JIRL:  cond_taken = 1'b1;
            default:               cond_taken = 1'b0;
        endcase
    end

    assign target = ((dec.br_kind == BR_JIRL) ? rj_value : pc) + dec.br_offs;

endmodule

`default_nettype wire

// File: hw/id_stage.sv
`default_nettype none

module id_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               fs_valid,
    input  id_pkg::fetch_bus_t fs_bus,
    output logic               ds_allowin,
    input  logic               es_allowin,
    output logic               es_valid_out,
    output id_pkg::exec_bus_t  es_bus,
    output id_pkg::br_bus_t    br,
    input  id_pkg::fwd_t       es_fwd,
    input  id_pkg::fwd_t       ms_fwd,
    input  id_pkg::fwd_t       ws_fwd,
    input  id_pkg::wb_t        wb
);
    import id_pkg::*;

    fetch_bus_t      ds_bus_r;
    logic            ds_valid;
    decode_t         dec;
    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] rj_value;
    logic [XLEN-1:0] rkd_value;
    logic            load_block;
    logic            cond_taken;
    logic [XLEN-1:0] br_target;
    logic            br_taken;

    // Stage handshake
    assign es_valid_out = ds_valid & ~load_block;
    assign ds_allowin   = ~ds_valid | (~load_block & es_allowin);
    assign br_taken     = cond_taken & es_valid_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            // A taken branch squashes the word fetch offers behind it
            ds_valid <= fs_valid & ~br_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_bus_r <= fs_bus;
        end
    end

    inst_decoder u_decoder (
        .inst (ds_bus_r.inst),
        .dec  (dec)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (dec.raddr1),
        .raddr2 (dec.raddr2),
        .wb     (wb),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    operand_forward u_forward (
        .dec        (dec),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .es_fwd     (es_fwd),
        .ms_fwd     (ms_fwd),
        .ws_fwd     (ws_fwd),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .load_block (load_block)
    );

    branch_unit u_branch (
        .dec        (dec),
        .pc         (ds_bus_r.pc),
        .rj_value   (rj_value),
        .rkd_value  (rkd_value),
        .cond_taken (cond_taken),
        .target     (br_target)
    );

    always_comb begin
        br.taken  = br_taken;
        br.target = br_target;
    end

    // Bundle toward execute
    always_comb begin
        es_bus.alu_op       = dec.alu_op;
        es_bus.src1_is_pc   = dec.src1_is_pc;
        es_bus.src2_is_imm  = dec.src2_is_imm;
        es_bus.res_from_mem = dec.res_from_mem;
        es_bus.gr_we        = dec.gr_we;
        es_bus.mem_we       = dec.mem_we;
        es_bus.ine          = dec.ine;
        es_bus.dest         = dec.dest;
        es_bus.imm          = dec.imm;
        es_bus.rj_value     = rj_value;
        es_bus.rkd_value    = rkd_value;
        es_bus.pc           = ds_bus_r.pc;
    end

endmodule

`default_nettype wire

// File: tests/id_stage_assertions.sv
`default_nettype none

module id_stage_assertions (
    input logic              clk,
    input logic              reset,
    input logic              es_valid_out,
    input logic              es_allowin,
    input id_pkg::exec_bus_t es_bus,
    input id_pkg::br_bus_t   br
);
    timeunit 1ns;
    timeprecision 1ps;

    // Stage comes out of reset empty
    empty_after_reset: assert property (@(posedge clk) reset |=> !es_valid_out && !br.taken)
        else $error("stage offered an output in the cycle after reset");

    held_bus_stable: assert property (@(posedge clk) disable iff (reset)
        es_valid_out && !es_allowin |=> $stable(es_bus))
        else $error("es_bus changed while execute held it back");

    // A fired taken branch squashes the word behind it
    taken_empties_stage: assert property (@(posedge clk) disable iff (reset)
        br.taken && es_allowin |=> !es_valid_out)
        else $error("stage still valid after a taken branch fired");

endmodule

bind id_stage id_stage_assertions u_assertions (
    .clk          (clk),
    .reset        (reset),
    .es_valid_out (es_valid_out),
    .es_allowin   (es_allowin),
    .es_bus       (es_bus),
    .br           (br)
);

`default_nettype wire

// File: tests/tb_id_stage.sv
`default_nettype none

module tb_id_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import id_pkg::*;

    localparam int NUM_TESTS = 6;
    localparam int BP_OFFERS = 30;

    typedef struct packed {
        exec_bus_t eb;
        br_bus_t   br;
        logic      stall;
    } expect_t;

    logic       clk = 1'b0;
    logic       reset;
    logic       fs_valid;
    fetch_bus_t fs_bus;
    logic       ds_allowin;
    logic       es_allowin = 1'b1;
    logic       es_valid_out;
    exec_bus_t  es_bus;
    br_bus_t    br;
    fwd_t       es_fwd;
    fwd_t       ms_fwd;
    fwd_t       ws_fwd;
    wb_t        wb;

    integer          seed;
    int              errors = 0;
    int              checks = 0;
    int              fires = 0;
    logic            bp_en = 1'b0;
    logic [31:0]     pc_next;
    logic [31:0]     model_regs [32];
    fetch_bus_t      stage_q [$];
    logic [4:0]      sub_codes [8] = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09, 5'h0a, 5'h0b};
    alu_op_e         rr_ops [8] = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
                                    ALU_NOR, ALU_AND, ALU_OR, ALU_XOR};

    id_stage dut0 (
        .clk          (clk),
        .reset        (reset),
        .fs_valid     (fs_valid),
        .fs_bus       (fs_bus),
        .ds_allowin   (ds_allowin),
        .es_allowin   (es_allowin),
        .es_valid_out (es_valid_out),
        .es_bus       (es_bus),
        .br           (br),
        .es_fwd       (es_fwd),
        .ms_fwd       (ms_fwd),
        .ws_fwd       (ws_fwd),
        .wb           (wb)
    );

    always #5 clk = ~clk;

    // Random execute back-pressure while enabled
    always @(posedge clk) begin
        #1;
        es_allowin = bp_en ? (($random(seed) & 3) != 0) : 1'b1;
    end

    always @(posedge clk) begin
        if (wb.we && wb.addr != 5'd0) begin
            model_regs[wb.addr] <= wb.data;
        end
    end

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] t;
        t = $random(seed);
        return (t[4:0] == 5'd0) ? 5'd1 : t[4:0];
    endfunction

    // Operand as seen by decode with the youngest producer first
    function automatic logic [31:0] operand(input logic [4:0] src, input logic used,
                                           input logic [31:0] regs [32],
                                           input fwd_t es, input fwd_t ms, input fwd_t ws);
        if (src == 5'd0) begin
            return 32'd0;
        end
        if (used && es.valid && es.gr_we && es.dest == src) begin
            return es.result;
        end
        if (used && ms.valid && ms.gr_we && ms.dest == src) begin
            return ms.result;
        end
        if (used && ws.valid && ws.gr_we && ws.dest == src) begin
            return ws.result;
        end
        return regs[src];
    endfunction

    function automatic logic load_hit(input logic [4:0] src, input logic used, input fwd_t es);
        return used && src != 5'd0 && es.valid && es.gr_we && es.is_load && es.dest == src;
    endfunction

    function automatic expect_t ref_model(input logic [31:0] inst, input logic [31:0] pc,
                                          input logic [31:0] regs [32],
                                          input fwd_t es, input fwd_t ms, input fwd_t ws);
        expect_t     e;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  r2;
        logic        use1;
        logic        use2;
        logic        legal;
        logic [31:0] si12;
        logic [31:0] o16;
        logic [31:0] a;
        logic [31:0] b;
        br_kind_e    kind;
        rd = inst[4:0];
        rj = inst[9:5];
        r2 = inst[14:10];
        si12 = {{20{inst[21]}}, inst[21:10]};
        o16 = {{14{inst[25]}}, inst[25:10], 2'b00};
        e = '0;
        e.eb.alu_op = ALU_ADD;
        e.eb.dest = rd;
        e.eb.pc = pc;
        kind = BR_NONE;
        use1 = 1'b0;
        use2 = 1'b0;
        legal = 1'b1;
        if (inst[31:20] == 12'h001) begin
            legal = 1'b0;
            for (int i = 0; i < 8; i++) begin
                if (inst[19:15] == sub_codes[i]) begin
                    legal = 1'b1;
                    e.eb.alu_op = rr_ops[i];
                end
            end
            e.eb.gr_we = legal;
            use1 = legal;
            use2 = legal;
        end else if (inst[31:22] == 10'h00a || inst[31:22] == 10'h0a2) begin
            // addi.w and ld.w share the si12 form
            e.eb.res_from_mem = inst[27];
            e.eb.src2_is_imm = 1'b1;
            e.eb.imm = si12;
            e.eb.gr_we = 1'b1;
            use1 = 1'b1;
        end else if (inst[31:25] == 7'h0a) begin
            e.eb.alu_op = ALU_LUI;
            e.eb.src2_is_imm = 1'b1;
            e.eb.imm = {inst[24:5], 12'h000};
            e.eb.gr_we = 1'b1;
        end else if (inst[31:22] == 10'h0a6) begin
            e.eb.mem_we = 1'b1;
            e.eb.src2_is_imm = 1'b1;
            e.eb.imm = si12;
            r2 = rd;
            use1 = 1'b1;
            use2 = 1'b1;
        end else begin
            case (inst[31:26])
                6'h13: kind = BR_JIRL;
                6'h14: kind = BR_B;
                6'h15: kind = BR_BL;
                6'h16: kind = BR_BEQ;
                6'h17: kind = BR_BNE;
                6'h18: kind = BR_BLT;
                6'h19: kind = BR_BGE;
                default: legal = 1'b0;
            endcase
            if (kind == BR_JIRL || kind == BR_BL) begin
                e.eb.src1_is_pc = 1'b1;
                e.eb.src2_is_imm = 1'b1;
                e.eb.imm = 32'd4;
                e.eb.gr_we = 1'b1;
                use1 = (kind == BR_JIRL);
                e.eb.dest = (kind == BR_BL) ? 5'd1 : rd;
            end else if (kind inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE}) begin
                r2 = rd;
                use1 = 1'b1;
                use2 = 1'b1;
            end
        end
        e.eb.ine = ~legal;
        a = operand(rj, use1, regs, es, ms, ws);
        b = operand(r2, use2, regs, es, ms, ws);
        e.eb.rj_value = a;
        e.eb.rkd_value = b;
        e.stall = load_hit(rj, use1, es) || load_hit(r2, use2, es);
        case (kind)
            BR_BEQ:  e.br.taken = (a == b);
            BR_BNE:  e.br.taken = (a != b);
            BR_BLT:  e.br.taken = ($signed(a) < $signed(b));
            BR_BGE:  e.br.taken = ($signed(a) >= $signed(b));
            BR_NONE: e.br.taken = 1'b0;
            default: e.br.taken = 1'b1;
        endcase
        if (kind == BR_B || kind == BR_BL) begin
            e.br.target = pc + {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        end else begin
            e.br.target = ((kind == BR_JIRL) ? a : pc) + o16;
        end
        return e;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Compare the stage content against the reference every cycle
    always @(negedge clk) begin
        fetch_bus_t cur;
        expect_t    e;
        if (!reset) begin
            // Fires as seen on the execute handshake
            if (es_valid_out && es_allowin) begin
                fires++;
            end
            if (stage_q.size() == 0) begin
                if (es_valid_out) begin
                    errors++;
                    $display("Stage offered an instruction that was never accepted at %0t", $time);
                end
            end else begin
                cur = stage_q[0];
                e = ref_model(cur.inst, cur.pc, model_regs, es_fwd, ms_fwd, ws_fwd);
                check_val("es_valid_out", es_valid_out, !e.stall);
                if (e.stall) begin
                    check_val("ds_allowin", ds_allowin, 1'b0);
                    check_val("br.taken", br.taken, 1'b0);
                end else if (es_allowin) begin
                    check_val("es_bus.pc", es_bus.pc, e.eb.pc);
                    check_val("es_bus.alu_op", es_bus.alu_op, e.eb.alu_op);
                    check_val("es_bus.src1_is_pc", es_bus.src1_is_pc, e.eb.src1_is_pc);
                    check_val("es_bus.src2_is_imm", es_bus.src2_is_imm, e.eb.src2_is_imm);
                    check_val("es_bus.res_from_mem", es_bus.res_from_mem, e.eb.res_from_mem);
                    check_val("es_bus.gr_we", es_bus.gr_we, e.eb.gr_we);
                    check_val("es_bus.mem_we", es_bus.mem_we, e.eb.mem_we);
                    check_val("es_bus.ine", es_bus.ine, e.eb.ine);
                    check_val("es_bus.dest", es_bus.dest, e.eb.dest);
                    check_val("es_bus.imm", es_bus.imm, e.eb.imm);
                    check_val("es_bus.rj_value", es_bus.rj_value, e.eb.rj_value);
                    check_val("es_bus.rkd_value", es_bus.rkd_value, e.eb.rkd_value);
                    check_val("br.taken", br.taken, e.br.taken);
                    if (e.br.taken) begin
                        check_val("br.target", br.target, e.br.target);
                    end
                    void'(stage_q.pop_front());
                end
            end
            if (fs_valid && ds_allowin && !br.taken) begin
                stage_q.push_back(fs_bus);
            end
        end
    end

    task automatic offer(input logic [31:0] inst);
        logic acc;
        fs_valid = 1'b1;
        fs_bus.inst = inst;
        fs_bus.pc = pc_next;
        acc = 1'b0;
        while (!acc) begin
            @(negedge clk);
            acc = ds_allowin;
            @(posedge clk);
            #1;
        end
        fs_valid = 1'b0;
        pc_next += 32'd4;
    endtask

    task automatic wait_drain();
        while (stage_q.size() != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("test %0d %s: %0d errors", num, name, errors - errs_before);
    endtask

    function automatic logic [31:0] rr_inst(input int k, input logic [4:0] rd,
                                            input logic [4:0] rj, input logic [4:0] rk);
        return {12'h001, sub_codes[k], rk, rj, rd};
    endfunction

    function automatic logic [31:0] rand_alu_inst();
        logic [31:0] t;
        int          k;
        t = rnd();
        k = int'(t[31:28]) % 12;
        case (k)
            8:       return {10'h00a, t[21:10], rand_reg(), rand_reg()};
            9:       return {7'h0a, t[24:5], rand_reg()};
            10:      return {10'h0a2, t[21:10], rand_reg(), rand_reg()};
            11:      return {10'h0a6, t[21:10], rand_reg(), rand_reg()};
            default: return rr_inst(k, rand_reg(), rand_reg(), rand_reg());
        endcase
    endfunction

    // Watchdog sized from the number of tests
    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        $display("Run timed out before all tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int          e0;
        int          f0;
        logic [4:0]  src;
        logic [4:0]  rj;
        logic [31:0] t;
        logic [31:0] w;
        expect_t     probe;
        seed = 35;
        reset = 1'b1;
        fs_valid = 1'b0;
        fs_bus = '0;
        es_fwd = '0;
        ms_fwd = '0;
        ws_fwd = '0;
        wb = '0;
        pc_next = 32'h1c00_0000;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 1; i < 32; i++) begin
            wb = {1'b1, 5'(i), rnd()};
            @(posedge clk);
            #1;
        end
        wb = '0;

        e0 = errors;
        for (int i = 0; i < 25; i++) begin
            offer(rand_alu_inst());
        end
        wait_drain();
        report_test(1, "alu and immediate", e0);

        e0 = errors;
        for (int i = 0; i < 12; i++) begin
            src = (i % 4 == 3) ? 5'd0 : rand_reg();
            t = rnd();
            es_fwd = {t[0], t[1], 1'b0, t[2] ? src : rand_reg(), rnd()};
            ms_fwd = {t[3], t[4], 1'b0, t[5] ? src : rand_reg(), rnd()};
            ws_fwd = {t[6], 1'b1, 1'b0, t[7] ? src : rand_reg(), rnd()};
            offer(rr_inst(0, rand_reg(), src, t[8] ? src : rand_reg()));
            wait_drain();
            es_fwd = '0;
            ms_fwd = '0;
            ws_fwd = '0;
        end
        report_test(2, "forwarding priority", e0);

        e0 = errors;
        for (int i = 0; i < 6; i++) begin
            src = rand_reg();
            es_fwd = {1'b1, 1'b1, 1'b1, src, rnd()};
            offer(rr_inst(i, rand_reg(), (i % 2 == 0) ? src : rand_reg(), src));
            repeat (3) @(posedge clk);
            #1;
            es_fwd = '0;
            ms_fwd = {1'b1, 1'b1, 1'b0, src, rnd()};
            wait_drain();
            ms_fwd = '0;
        end
        report_test(3, "load-use", e0);

        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            t = rnd();
            rj = rand_reg();
            src = t[0] ? rj : rand_reg();
            w = {6'h13 + 6'(i % 7), t[25:10], rj, src};
            offer(w);
            offer(rand_alu_inst());
            wait_drain();
        end
        report_test(4, "branches", e0);

        e0 = errors;
        f0 = fires;
        bp_en = 1'b1;
        for (int i = 0; i < BP_OFFERS; i++) begin
            offer(rand_alu_inst());
        end
        wait_drain();
        bp_en = 1'b0;
        check_val("fired count", 64'(fires - f0), 64'(BP_OFFERS));
        report_test(5, "back-pressure", e0);

        e0 = errors;
        for (int i = 0; i < 15; i++) begin
            w = rnd();
            probe = ref_model(w, 32'd0, model_regs, es_fwd, ms_fwd, ws_fwd);
            while (!probe.eb.ine) begin
                w = rnd();
                probe = ref_model(w, 32'd0, model_regs, es_fwd, ms_fwd, ws_fwd);
            end
            offer(w);
        end
        wait_drain();
        report_test(6, "illegal encodings", e0);

        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hw/id_pkg.sv
hw/inst_decoder.sv
hw/regfile.sv
hw/operand_forward.sv
hw/branch_unit.sv
hw/id_stage.sv
tests/id_stage_assertions.sv
tests/tb_id_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module tb_id_stage \
    -o sim_id_stage && ./obj_dir/sim_id_stage > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Simulation finished: PASS$" sim.log && echo "run_sim: passed" || {
    echo "run_sim: failed"
    exit 1
}
